//--- logic/dnc_gate_params.svh
// DNC interface gate sizes
// Scalar format, read head count and buffer depth shared by
// the sequencer, the buffer, the evaluator and the consumer

`ifndef DNC_GATE_PARAMS_SVH
`define DNC_GATE_PARAMS_SVH

// Q8.8 two's complement scalar
`define DNC_DATA_W 16
`define DNC_FRAC_W 8

// One free gate per read head
`define DNC_READ_HEADS 2
`define DNC_HEAD_W 1

// Entries waiting ahead of the evaluator
`define DNC_FIFO_DEPTH 4

`endif

//--- logic/dnc_gate_pkg.sv
// DNC interface gate types
// Gate opcodes tagged onto each raw scalar and the states of the
// scalar logistic evaluator

package dnc_gate_pkg;

  // Gate kind carried with every scalar
  // Reserved code is rejected by the sequencer
  typedef enum logic [1:0] {
    GATE_WRITE = 2'd0,
    GATE_ALLOC = 2'd1,
    GATE_FREE  = 2'd2,
    GATE_RSVD  = 2'd3
  } gate_op_t;

  // Evaluator walk, one state per cycle after start
  typedef enum logic [1:0] {
    LOG_IDLE     = 2'd0,
    LOG_CLASSIFY = 2'd1,
    LOG_SCALE    = 2'd2,
    LOG_FOLD     = 2'd3
  } logistic_state_t;

endpackage

//--- logic/dnc_gate_sequencer.sv
// DNC gate sequencer
// Checks each host scalar strobe against the gate rules and turns
// legal ones into buffer pushes in the same cycle. Illegal opcodes,
// out of range free heads and strobes while full are dropped, and
// raise sticky error flags held until reset

`timescale 1ns/1ns

`include "dnc_gate_params.svh"

module dnc_gate_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  dnc_gate_pkg::gate_op_t  in_op,
  input  logic [`DNC_HEAD_W-1:0]  in_head,
  input  logic [`DNC_DATA_W-1:0]  in_value,
  input  logic                    full,
  output logic                    push,
  output dnc_gate_pkg::gate_op_t  push_op,
  output logic [`DNC_HEAD_W-1:0]  push_head,
  output logic [`DNC_DATA_W-1:0]  push_value,
  output logic                    overflow,
  output logic                    bad_op
);

  import dnc_gate_pkg::*;

  logic is_free;
  logic head_bad;
  logic op_bad;
  logic legal;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode and head checks
  ////////////////////////////////////////////////////////////////////////////

  assign is_free  = (in_op == GATE_FREE);
  // Free gate must name an existing read head
  assign head_bad = is_free &&
                    ({1'b0, in_head} >= (`DNC_HEAD_W + 1)'(`DNC_READ_HEADS));
  assign op_bad   = (in_op == GATE_RSVD) || head_bad;
  assign legal    = !op_bad;

  // Push straight through, written at the sampling edge
  assign push       = in_valid && legal && !full;
  assign push_op    = in_op;
  assign push_value = in_value;
  // Write and alloc gates are global, head forced to zero
  assign push_head  = is_free ? in_head : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Sticky error flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
      bad_op   <= 1'b0;
    end else begin
      // Strobe lost to a full buffer
      if (in_valid && full) begin
        overflow <= 1'b1;
      end
      // Strobe with an illegal tag
      if (in_valid && op_bad) begin
        bad_op <= 1'b1;
      end
    end
  end

endmodule

//--- logic/dnc_gate_fifo.sv
// DNC gate buffer
// Circular first-in first-out store of tagged gate scalars.
// Head entry shows on the read fields whenever empty is low;
// push and pop in one cycle are both taken

`timescale 1ns/1ns

`include "dnc_gate_params.svh"

module dnc_gate_fifo #(
  parameter int DEPTH = `DNC_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push,
  input  dnc_gate_pkg::gate_op_t  push_op,
  input  logic [`DNC_HEAD_W-1:0]  push_head,
  input  logic [`DNC_DATA_W-1:0]  push_value,
  input  logic                    pop,
  output dnc_gate_pkg::gate_op_t  pop_op,
  output logic [`DNC_HEAD_W-1:0]  pop_head,
  output logic [`DNC_DATA_W-1:0]  pop_value,
  output logic                    full,
  output logic                    empty
);

  import dnc_gate_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry fields kept side by side
  gate_op_t               op_mem    [DEPTH];
  logic [`DNC_HEAD_W-1:0] head_mem  [DEPTH];
  logic [`DNC_DATA_W-1:0] value_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head entry, read without a register stage
  assign pop_op    = op_mem[rd_ptr];
  assign pop_head  = head_mem[rd_ptr];
  assign pop_value = value_mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        // Wrap at DEPTH, not only at a power of two
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (do_push) begin
      op_mem[wr_ptr]    <= push_op;
      head_mem[wr_ptr]  <= push_head;
      value_mem[wr_ptr] <= push_value;
    end
  end

endmodule

//--- logic/ntm_scalar_logistic.sv
// Scalar logistic evaluator
// Piecewise-linear sigmoid on a Q8.8 input. All slopes are powers
// of two, so the datapath is shifts and adds only. Start is taken
// in idle; ready and data_out come three cycles later, after the
// classify, scale and fold steps

`timescale 1ns/1ns

`include "dnc_gate_params.svh"

module ntm_scalar_logistic (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic [`DNC_DATA_W-1:0] data_in,
  output logic                   ready,
  output logic [`DNC_DATA_W-1:0] data_out
);

  import dnc_gate_pkg::*;

  localparam int W = `DNC_DATA_W;
  localparam int F = `DNC_FRAC_W;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed-point constants
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [W-1:0] FX_ONE   = W'(1 << F);
  localparam logic [W-1:0] FX_HALF  = W'(1 << (F - 1));
  // 0.625 and 0.84375
  localparam logic [W-1:0] OFS_MID  = W'((5 << F) >> 3);
  localparam logic [W-1:0] OFS_HIGH = W'((27 << F) >> 5);
  // Segment knees 2.375 and 5.0, lowest knee is FX_ONE
  localparam logic [W-1:0] KNEE_HI  = W'((19 << F) >> 3);
  localparam logic [W-1:0] KNEE_SAT = W'(5 << F);

  // Segment codes
  localparam logic [1:0] SEG_LOW  = 2'd0;
  localparam logic [1:0] SEG_MID  = 2'd1;
  localparam logic [1:0] SEG_HIGH = 2'd2;
  localparam logic [1:0] SEG_SAT  = 2'd3;

  logistic_state_t state_q;

  logic         sign_q;
  logic [W-1:0] mag_q;
  logic [1:0]   seg_q;
  logic [W-1:0] y_q;

  logic [W-1:0] mag_in;
  logic [1:0]   seg_next;

  // |x|, full negative range fits as unsigned
  assign mag_in = data_in[W-1] ? (~data_in + 1'b1) : data_in;

  // Segment of the magnitude
  always_comb begin
    if (mag_q >= KNEE_SAT) begin
      seg_next = SEG_SAT;
    end else if (mag_q >= KNEE_HI) begin
      seg_next = SEG_HIGH;
    end else if (mag_q >= FX_ONE) begin
      seg_next = SEG_MID;
    end else begin
      seg_next = SEG_LOW;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= LOG_IDLE;
    end else begin
      case (state_q)
        LOG_IDLE:     if (start) state_q <= LOG_CLASSIFY;
        LOG_CLASSIFY: state_q <= LOG_SCALE;
        LOG_SCALE:    state_q <= LOG_FOLD;
        default:      state_q <= LOG_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Capture sign and magnitude on start
    if (state_q == LOG_IDLE && start) begin
      sign_q <= data_in[W-1];
      mag_q  <= mag_in;
    end
    if (state_q == LOG_CLASSIFY) begin
      seg_q <= seg_next;
    end
    // Shift and add, shifts truncate
    if (state_q == LOG_SCALE) begin
      case (seg_q)
        SEG_LOW:  y_q <= (mag_q >> 2) + FX_HALF;
        SEG_MID:  y_q <= (mag_q >> 3) + OFS_MID;
        SEG_HIGH: y_q <= (mag_q >> 5) + OFS_HIGH;
        default:  y_q <= FX_ONE;
      endcase
    end
  end

  // Fold by symmetry, sigmoid(-x) = 1 - sigmoid(x)
  assign ready    = (state_q == LOG_FOLD);
  assign data_out = sign_q ? (FX_ONE - y_q) : y_q;

endmodule

//--- logic/dnc_interface_gates.sv
// DNC interface gate consumer
// Drains the gate buffer one entry at a time through the scalar
// logistic evaluator and publishes each result with its gate kind
// and head as a one-cycle valid pulse

`timescale 1ns/1ns

`include "dnc_gate_params.svh"

module dnc_interface_gates (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    empty,
  input  dnc_gate_pkg::gate_op_t  pop_op,
  input  logic [`DNC_HEAD_W-1:0]  pop_head,
  input  logic [`DNC_DATA_W-1:0]  pop_value,
  output logic                    pop,
  output logic                    gate_valid,
  output dnc_gate_pkg::gate_op_t  gate_op,
  output logic [`DNC_HEAD_W-1:0]  gate_head,
  output logic [`DNC_DATA_W-1:0]  gate_value
);

  import dnc_gate_pkg::*;

  // Evaluator handshake
  logic                   start_logistic;
  logic                   ready_logistic;
  logic [`DNC_DATA_W-1:0] data_out_logistic;

  // Entry in flight
  logic                   busy;
  gate_op_t               tag_op;
  logic [`DNC_HEAD_W-1:0] tag_head;

  ////////////////////////////////////////////////////////////////////////////
  // Issue
  ////////////////////////////////////////////////////////////////////////////

  // One scalar at a time, pop and start together
  assign pop            = !empty && !busy;
  assign start_logistic = pop;

  ntm_scalar_logistic u_logistic (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start_logistic),
    .data_in  (pop_value),
    .ready    (ready_logistic),
    .data_out (data_out_logistic)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Busy tracking and result publish
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      gate_valid <= 1'b0;
    end else begin
      // Ready never meets pop, busy is still set then
      if (ready_logistic) begin
        busy <= 1'b0;
      end else if (pop) begin
        busy <= 1'b1;
      end
      gate_valid <= ready_logistic;
    end
  end

  // Tag and result payload
  always_ff @(posedge clk) begin
    if (pop) begin
      tag_op   <= pop_op;
      tag_head <= pop_head;
    end
    if (ready_logistic) begin
      gate_op    <= tag_op;
      gate_head  <= tag_head;
      gate_value <= data_out_logistic;
    end
  end

endmodule

//--- logic/dnc_gate_top.sv
// DNC interface gate stage
// Host scalars pass the sequencer checks, wait in the gate buffer
// and go through the logistic consumer one at a time

`timescale 1ns/1ns

`include "dnc_gate_params.svh"

module dnc_gate_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  dnc_gate_pkg::gate_op_t  in_op,
  input  logic [`DNC_HEAD_W-1:0]  in_head,
  input  logic [`DNC_DATA_W-1:0]  in_value,
  output logic                    full,
  output logic                    overflow,
  output logic                    bad_op,
  output logic                    gate_valid,
  output dnc_gate_pkg::gate_op_t  gate_op,
  output logic [`DNC_HEAD_W-1:0]  gate_head,
  output logic [`DNC_DATA_W-1:0]  gate_value
);

  import dnc_gate_pkg::*;

  // Sequencer to buffer
  logic                   push;
  gate_op_t               push_op;
  logic [`DNC_HEAD_W-1:0] push_head;
  logic [`DNC_DATA_W-1:0] push_value;

  // Buffer to consumer
  logic                   pop;
  logic                   empty;
  gate_op_t               pop_op;
  logic [`DNC_HEAD_W-1:0] pop_head;
  logic [`DNC_DATA_W-1:0] pop_value;

  ////////////////////////////////////////////////////////////////////////////
  // Producer, buffer and consumer
  ////////////////////////////////////////////////////////////////////////////

  dnc_gate_sequencer u_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_head    (in_head),
    .in_value   (in_value),
    .full       (full),
    .push       (push),
    .push_op    (push_op),
    .push_head  (push_head),
    .push_value (push_value),
    .overflow   (overflow),
    .bad_op     (bad_op)
  );

  dnc_gate_fifo #(
    .DEPTH (`DNC_FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_op    (push_op),
    .push_head  (push_head),
    .push_value (push_value),
    .pop        (pop),
    .pop_op     (pop_op),
    .pop_head   (pop_head),
    .pop_value  (pop_value),
    .full       (full),
    .empty      (empty)
  );

  dnc_interface_gates u_gates (
    .clk        (clk),
    .rst_n      (rst_n),
    .empty      (empty),
    .pop_op     (pop_op),
    .pop_head   (pop_head),
    .pop_value  (pop_value),
    .pop        (pop),
    .gate_valid (gate_valid),
    .gate_op    (gate_op),
    .gate_head  (gate_head),
    .gate_value (gate_value)
  );

endmodule

//--- test/dnc_gate_checker.sv
// DNC gate stage checker
// Watches the host side and the result side of the gate stage.
// Predicts which strobes the sequencer takes, queues their expected
// results in order, and compares every gate_valid pulse, the full
// level and the two sticky error flags against that model

`timescale 1ns/1ns

`include "dnc_gate_params.svh"

module dnc_gate_checker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  dnc_gate_pkg::gate_op_t  in_op,
  input  logic [`DNC_HEAD_W-1:0]  in_head,
  input  logic [`DNC_DATA_W-1:0]  exp_value,
  input  logic                    full,
  input  logic                    overflow,
  input  logic                    bad_op,
  input  logic                    gate_valid,
  input  dnc_gate_pkg::gate_op_t  gate_op,
  input  logic [`DNC_HEAD_W-1:0]  gate_head,
  input  logic [`DNC_DATA_W-1:0]  gate_value,
  output int                      value_errors,
  output int                      other_errors,
  output int                      checked,
  output int                      pending
);

  import dnc_gate_pkg::*;

  localparam int ENTRY_W = 2 + `DNC_HEAD_W + `DNC_DATA_W;
  // Cycles the consumer stays busy after each pop
  localparam int EVAL_CYCLES = 3;

  // Expected results with the oldest first
  logic [ENTRY_W-1:0]     expect_q [$];
  logic [ENTRY_W-1:0]     front;
  logic [1:0]             want_op;
  logic [`DNC_HEAD_W-1:0] want_head;
  logic [`DNC_DATA_W-1:0] want_value;
  logic                   legal;
  logic                   exp_overflow;
  logic                   exp_bad_op;

  // Buffer occupancy model
  int                     model_count;
  int                     busy_left;
  logic                   model_full;
  logic                   model_push;
  logic                   model_pop;

  // Reserved code is illegal and a free gate needs a real head
  function automatic logic input_legal(input gate_op_t op, input logic [`DNC_HEAD_W-1:0] head);
    if (op == GATE_RSVD) begin
      return 1'b0;
    end
    return !(op == GATE_FREE && 32'(head) >= `DNC_READ_HEADS);
  endfunction

  always @(posedge clk) begin
    if (!rst_n) begin
      expect_q.delete();
      exp_overflow = 1'b0;
      exp_bad_op   = 1'b0;
      model_count  = 0;
      busy_left    = 0;
      value_errors = 0;
      other_errors = 0;
      checked      = 0;
    end else begin
      // Flags as left by the previous edge
      if (overflow !== exp_overflow) begin
        other_errors++;
        $display("Fail overflow: got %h expected %h at %0t", overflow, exp_overflow, $time);
      end
      if (bad_op !== exp_bad_op) begin
        other_errors++;
        $display("Fail bad_op: got %h expected %h at %0t", bad_op, exp_bad_op, $time);
      end

      // Full once every buffer slot is taken
      model_full = (model_count == `DNC_FIFO_DEPTH);
      if (full !== model_full) begin
        other_errors++;
        $display("Fail full: got %h expected %h at %0t", full, model_full, $time);
      end

      ////////////////////////////////////////////////////////////////////////////
      // Result side
      ////////////////////////////////////////////////////////////////////////////
      if (gate_valid === 1'b1) begin
        if (expect_q.size() == 0) begin
          other_errors++;
          $display("gate_valid pulsed with no accepted input waiting at %0t", $time);
        end else begin
          front      = expect_q.pop_front();
          want_op    = front[ENTRY_W-1 -: 2];
          want_head  = front[`DNC_DATA_W +: `DNC_HEAD_W];
          want_value = front[`DNC_DATA_W-1:0];
          checked++;
          if (gate_op !== want_op) begin
            value_errors++;
            $display("Fail gate_op: got %h expected %h", gate_op, want_op);
          end
          if (gate_head !== want_head) begin
            value_errors++;
            $display("Fail gate_head: got %h expected %h", gate_head, want_head);
          end
          if (gate_value !== want_value) begin
            value_errors++;
            $display("Fail gate_value: got %h expected %h", gate_value, want_value);
          end
        end
      end else if (gate_valid !== 1'b0) begin
        other_errors++;
        $display("gate_valid is unknown at %0t", $time);
      end

      ////////////////////////////////////////////////////////////////////////////
      // Host side as sampled at this edge
      ////////////////////////////////////////////////////////////////////////////
      if (in_valid) begin
        legal = input_legal(in_op, in_head);
        if (full) begin
          exp_overflow = 1'b1;
        end
        if (!legal) begin
          exp_bad_op = 1'b1;
        end
        // Write and alloc gates come out on head zero
        if (legal && !full) begin
          expect_q.push_back({in_op, (in_op == GATE_FREE) ? in_head : `DNC_HEAD_W'(0),
                              exp_value});
        end
      end

      ////////////////////////////////////////////////////////////////////////////
      // Occupancy after this edge
      ////////////////////////////////////////////////////////////////////////////
      // Consumer pops whenever the evaluator is free
      model_pop   = (model_count > 0) && (busy_left == 0);
      model_push  = in_valid && input_legal(in_op, in_head) && !model_full;
      model_count = model_count + int'(model_push) - int'(model_pop);
      if (model_pop) begin
        busy_left = EVAL_CYCLES;
      end else if (busy_left > 0) begin
        busy_left--;
      end
    end
    pending = expect_q.size();
  end

endmodule

//--- test/dnc_gate_tb.sv
// DNC gate stage testbench
// Reads tagged raw scalars from the vector file and drives them into
// the gate stage on the falling edge, with random idle gaps except
// inside marked bursts. The checker does the comparing. The run ends
// once every accepted entry has come out, or at a cycle limit

`timescale 1ns/1ns

`include "dnc_gate_params.svh"

module dnc_gate_tb;

  import dnc_gate_pkg::*;

  localparam int    CLK_PERIOD   = 20;
  localparam int    RESET_CYCLES = 3;
  // Window after drain for stray gate_valid pulses
  localparam int    QUIET_CYCLES = 10;
  localparam string VECTOR_FILE  = "test/dnc_gate_vectors.txt";

  logic                   clk;
  logic                   rst_n;
  logic                   in_valid;
  gate_op_t               in_op;
  logic [`DNC_HEAD_W-1:0] in_head;
  logic [`DNC_DATA_W-1:0] in_value;
  logic [`DNC_DATA_W-1:0] exp_value;
  logic                   full;
  logic                   overflow;
  logic                   bad_op;
  logic                   gate_valid;
  gate_op_t               gate_op;
  logic [`DNC_HEAD_W-1:0] gate_head;
  logic [`DNC_DATA_W-1:0] gate_value;

  int value_errors;
  int other_errors;
  int checked;
  int pending;

  // Vector table with one slot per data line
  logic                   vec_burst [$];
  logic [1:0]             vec_op    [$];
  logic [`DNC_HEAD_W-1:0] vec_head  [$];
  logic [`DNC_DATA_W-1:0] vec_value [$];
  logic [`DNC_DATA_W-1:0] vec_gate  [$];

  int          file_errors = 0;
  int          cycles      = 0;
  int          cycle_limit = 0;
  logic [31:0] rng_state;

  dnc_gate_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_head    (in_head),
    .in_value   (in_value),
    .full       (full),
    .overflow   (overflow),
    .bad_op     (bad_op),
    .gate_valid (gate_valid),
    .gate_op    (gate_op),
    .gate_head  (gate_head),
    .gate_value (gate_value)
  );

  dnc_gate_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .in_op        (in_op),
    .in_head      (in_head),
    .exp_value    (exp_value),
    .full         (full),
    .overflow     (overflow),
    .bad_op       (bad_op),
    .gate_valid   (gate_valid),
    .gate_op      (gate_op),
    .gate_head    (gate_head),
    .gate_value   (gate_value),
    .value_errors (value_errors),
    .other_errors (other_errors),
    .checked      (checked),
    .pending      (pending)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Run limit scales with the vector count
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d results still pending", cycles, pending);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Vector file and stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    int    burst;
    int    op;
    int    head;
    int    value;
    int    gate;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      $display("Could not open vector file %s", VECTOR_FILE);
      file_errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // Comment and blank lines match no fields
        if (n > 0 && $sscanf(line, "%h %h %h %h %h", burst, op, head, value, gate) == 5) begin
          vec_burst.push_back(burst[0]);
          vec_op.push_back(op[1:0]);
          vec_head.push_back(head[`DNC_HEAD_W-1:0]);
          vec_value.push_back(value[`DNC_DATA_W-1:0]);
          vec_gate.push_back(gate[`DNC_DATA_W-1:0]);
        end
      end
      $fclose(fd);
      if (vec_op.size() == 0) begin
        $display("Vector file holds no data lines");
        file_errors++;
      end
    end
  endtask

  task automatic apply_vector(input int idx);
    in_valid  = 1'b1;
    in_op     = gate_op_t'(vec_op[idx]);
    in_head   = vec_head[idx];
    in_value  = vec_value[idx];
    exp_value = vec_gate[idx];
  endtask

  initial begin
    logic [1:0] gap;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_op     = GATE_WRITE;
    in_head   = '0;
    in_value  = '0;
    exp_value = '0;
    rng_state = 32'd79105;
    load_vectors();
    cycle_limit = 20 * vec_op.size() + 100;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < vec_op.size(); i++) begin
      @(negedge clk);
      apply_vector(i);
      rng_state = xorshift32(rng_state);
      // Burst lines run back to back
      gap = vec_burst[i] ? 2'd0 : rng_state[1:0];
      repeat (gap) begin
        @(negedge clk);
        in_valid = 1'b0;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;

    // Drain and then watch for stray results
    while (pending != 0) @(negedge clk);
    repeat (QUIET_CYCLES) @(negedge clk);

    $display("Closing: %0d value errors, %0d other errors, %0d file errors, %0d checked",
             value_errors, other_errors, file_errors, checked);
    if (value_errors + other_errors + file_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- test/dnc_gate_vectors.txt
# burst op head value expected_gate, all hex; op 0 write 1 alloc 2 free 3 reserved
# burst 1 means the next line follows with no idle cycle
0 0 0 0000 0080
0 1 0 0100 00C0
0 2 0 0080 00A0
0 2 1 FF00 0040
0 0 1 0040 0090
0 0 0 00FF 00BF
0 1 0 025F 00EB
0 2 1 0260 00EB
0 0 0 04FF 00FF
0 1 0 0500 0100
0 2 0 FB00 0000
0 0 0 7FFF 0100
0 1 0 8000 0000
0 2 1 FF01 0041
0 0 0 FDA0 0015
0 1 0 0180 00D0
0 2 0 FE80 0030
0 0 0 FFFF 0080
0 3 0 0100 0000
0 1 0 0200 00E0
1 1 0 0100 00C0
1 1 0 FF00 0040
1 2 1 0080 00A0
1 2 0 0300 00F0
1 0 0 FD00 0010
1 1 0 0500 0100
1 2 1 0000 0080
1 0 0 0180 00D0
0 2 1 0040 0090
0 0 0 F600 0000
0 3 1 FFFF 0000
0 1 1 FFC0 0070

//--- files.f
+incdir+logic
logic/dnc_gate_pkg.sv
logic/dnc_gate_sequencer.sv
logic/dnc_gate_fifo.sv
logic/ntm_scalar_logistic.sv
logic/dnc_interface_gates.sv
logic/dnc_gate_top.sv
test/dnc_gate_checker.sv
test/dnc_gate_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the gate stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module dnc_gate_tb \
  --Mdir obj_dir -o dnc_gate_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/dnc_gate_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
